// ==== conv_store.f ====
rtl/conv_store_pkg.sv
rtl/conv_out_fifo_bank.sv
rtl/store_tile_sequencer.sv
rtl/conv_store_ddr_controller.sv
rtl/conv_store_top.sv
verif/ddr_store_model.sv
verif/conv_store_tb.sv

// ==== rtl/conv_out_fifo_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_out_fifo_bank #(
  parameter int fifo_depth = 64
) (
  input wire clk,
  input wire reset,
  input wire [conv_store_pkg::fifo_num-1:0] fifo_wr,
  input wire conv_store_pkg::fifo_word_u fifo_wr_data,
  input wire [conv_store_pkg::fifo_num-1:0] fifo_rds,
  output conv_store_pkg::fifo_word_u fifo_data,
  output logic fifo_overflow
);
  import conv_store_pkg::*;

  localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_width = $clog2(fifo_depth + 1);

  wire fifo_word_u head [fifo_num];
  wire [fifo_num-1:0] full;
  fifo_word_u rd_head;

  ////////////////////
  // one circular buffer per systolic array
  ////////////////////
  for (genvar i = 0; i < fifo_num; i++) begin : g_fifo
    fifo_word_u mem [fifo_depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;
    logic do_wr;
    logic do_rd;

    assign full[i] = (count == cnt_width'(fifo_depth));
    assign do_wr = fifo_wr[i] && !full[i];
    // reads of an empty fifo leave the pointers alone
    assign do_rd = fifo_rds[i] && (count != '0);
    assign head[i] = mem[rd_ptr];

    always_ff @(posedge clk) begin
      if (do_wr) begin
        mem[wr_ptr] <= fifo_wr_data;
      end
    end

    always_ff @(posedge clk) begin
      if (reset) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
      end else begin
        if (do_wr) begin
          wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (do_rd) begin
          rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
        end
        count <= count + cnt_width'(do_wr) - cnt_width'(do_rd);
      end
    end
  end

  ////////////////////
  // read mux
  ////////////////////
  // one-hot select of the fifo heads
  always_comb begin
    rd_head = '0;
    for (int k = 0; k < fifo_num; k++) begin
      if (fifo_rds[k]) begin
        rd_head = head[k];
      end
    end
  end

  // data lands one cycle after the read strobe
  always_ff @(posedge clk) begin
    if (|fifo_rds) begin
      fifo_data <= rd_head;
    end
  end

  // sticky until reset
  always_ff @(posedge clk) begin
    if (reset) begin
      fifo_overflow <= 1'b0;
    end else if (|(fifo_wr & full)) begin
      fifo_overflow <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/conv_store_ddr_controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_store_ddr_controller #(
  parameter int ddr_cmd_word_num = 32
) (
  input wire clk,
  input wire reset,
  input wire conv_store_start,
  input wire ddr_cmd_ready,
  input wire ddr_wt_data_ready,
  input wire [31:0] output_ddr_layer_base_adr,
  input wire conv_store_pkg::store_mode_e mode,
  input wire [3:0] of_in_2pow,
  input wire [3:0] ox_in_2pow,
  input wire [15:0] cur_ox_start,
  input wire [15:0] cur_oy_start,
  input wire [15:0] cur_of_start,
  input wire [15:0] cur_poy,
  input wire [15:0] cur_pof,
  output logic [31:0] store_ddr_base_adr,
  output logic [15:0] store_ddr_length,
  output logic valid_store_ddr_cmd,
  output logic [conv_store_pkg::fifo_num-1:0] fifo_rds,
  input wire conv_store_pkg::fifo_word_u fifo_data,
  output logic [31:0] conv_out_ddr_adr,
  output logic [conv_store_pkg::ddr_word_width-1:0] conv_out_ddr_data,
  output logic valid_conv_out_ddr_data,
  output logic conv_store_fin
);
  import conv_store_pkg::*;

  // store and burst state
  logic store_active;
  logic burst_open;
  logic burst_busy;
  logic mode_ok;

  // command loop
  logic [15:0] store_of_counter;
  logic [15:0] store_oy_counter;
  logic [15:0] remain_words;
  logic cmd_fire;
  logic cmd_row_end;

  // data loop
  logic [15:0] channel_counter;
  logic [15:0] of_counter;
  logic [15:0] oy_counter;
  logic [15:0] channel_num;
  logic [3:0] log_channel_num;
  logic [15:0] channel_step;
  logic [15:0] burst_length;
  logic [15:0] burst_word_cnt;
  logic [15:0] fifo_idx;
  logic rd_fire;
  logic word_done;
  logic burst_end;
  logic ch_end;
  logic of_end;
  logic oy_end;

  // address terms and pairing
  logic [4:0] row_shift;
  logic [31:0] x_word;
  logic [conv_word_width-1:0] conv_hist;

  function automatic logic [31:0] ddr_adr(
    input logic [31:0] base,
    input logic [4:0] shift,
    input logic [31:0] xw,
    input logic [15:0] row,
    input logic [15:0] ch
  );
    logic [31:0] row_adr;
    row_adr = 32'(row) << shift;
    // two channels per address step
    return base + row_adr + xw + (32'(ch) >> ofs_in_row_2pow);
  endfunction

  assign mode_ok = (mode == mode_8x8) || (mode == mode_1x8);
  assign channel_num = (mode == mode_1x8) ? 16'(row_num_in_sa << 1) : 16'(row_num_in_sa);
  assign log_channel_num = (mode == mode_1x8) ? 4'(row_num_in_sa_in2pow + 1) :
                                                4'(row_num_in_sa_in2pow);
  assign channel_step = (mode == mode_1x8) ? 16'd2 : 16'd1;

  assign row_shift = 5'(of_in_2pow) + 5'(ox_in_2pow) -
                     5'(ofs_in_row_2pow + pixels_in_row_in_2pow);
  assign x_word = (32'(cur_ox_start) << (of_in_2pow - 4'(ofs_in_row_2pow))) >>
                  pixels_in_row_in_2pow;

  ////////////////////
  // store commands
  ////////////////////
  assign remain_words = (cur_pof - store_of_counter) >> ofs_in_row_2pow;
  assign store_ddr_length = (remain_words > 16'(ddr_cmd_word_num)) ? 16'(ddr_cmd_word_num) :
                                                                       remain_words;
  // burst stays open until its last word has left
  assign burst_busy = burst_open || valid_conv_out_ddr_data;
  assign cmd_fire = store_active && !burst_busy && ddr_cmd_ready;
  assign valid_store_ddr_cmd = cmd_fire;
  assign cmd_row_end = (store_of_counter + (store_ddr_length << ofs_in_row_2pow)) >= cur_pof;
  assign store_ddr_base_adr = ddr_adr(output_ddr_layer_base_adr, row_shift, x_word,
                                      cur_oy_start + store_oy_counter,
                                      cur_of_start + store_of_counter);

  // unsupported modes never open a store
  always_ff @(posedge clk) begin
    if (reset) begin
      store_active <= 1'b0;
    end else if (conv_store_start && mode_ok) begin
      store_active <= 1'b1;
    end else if (oy_end) begin
      store_active <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      store_of_counter <= '0;
      store_oy_counter <= '0;
    end else if (cmd_fire) begin
      if (cmd_row_end) begin
        store_of_counter <= '0;
        store_oy_counter <= (store_oy_counter == cur_poy - 16'd1) ? '0 :
                                                                   store_oy_counter + 16'd1;
      end else begin
        store_of_counter <= store_of_counter + (store_ddr_length << ofs_in_row_2pow);
      end
    end
  end

  // word count of the open burst
  assign burst_end = word_done && (burst_word_cnt == burst_length - 16'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      burst_open <= 1'b0;
      burst_length <= '0;
      burst_word_cnt <= '0;
    end else if (cmd_fire) begin
      burst_open <= 1'b1;
      burst_length <= store_ddr_length;
      burst_word_cnt <= '0;
    end else if (word_done) begin
      burst_word_cnt <= burst_word_cnt + 16'd1;
      if (burst_end) begin
        burst_open <= 1'b0;
      end
    end
  end

  ////////////////////
  // fifo read sequencing
  ////////////////////
  // odd half of an 8x8 pair goes without waiting on ready
  assign rd_fire = burst_open && mode_ok &&
                   (ddr_wt_data_ready || ((mode == mode_8x8) && channel_counter[0]));
  assign word_done = rd_fire && ((mode == mode_1x8) || channel_counter[0]);

  assign ch_end = rd_fire && ((channel_counter + channel_step >= channel_num) ||
                              (of_counter + channel_counter + channel_step >= cur_pof));
  assign of_end = ch_end && (of_counter + channel_num >= cur_pof);
  assign oy_end = of_end && (oy_counter == cur_poy - 16'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      channel_counter <= '0;
      of_counter <= '0;
      oy_counter <= '0;
    end else if (rd_fire) begin
      if (ch_end) begin
        channel_counter <= '0;
        if (of_end) begin
          of_counter <= '0;
          oy_counter <= oy_end ? '0 : oy_counter + 16'd1;
        end else begin
          of_counter <= of_counter + channel_num;
        end
      end else begin
        channel_counter <= channel_counter + channel_step;
      end
    end
  end

  // row picks the array row of fifos, filter group picks the column
  assign fifo_idx = 16'(oy_counter * sa_row_num) + (of_counter >> log_channel_num);

  always_comb begin
    fifo_rds = '0;
    for (int k = 0; k < fifo_num; k++) begin
      if (rd_fire && (fifo_idx == 16'(k))) begin
        fifo_rds[k] = 1'b1;
      end
    end
  end

  ////////////////////
  // ddr words
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_conv_out_ddr_data <= 1'b0;
      conv_store_fin <= 1'b0;
    end else begin
      valid_conv_out_ddr_data <= word_done;
      conv_store_fin <= oy_end;
    end
  end

  // odd channel shares the address of its even partner
  always_ff @(posedge clk) begin
    if (word_done) begin
      conv_out_ddr_adr <= ddr_adr(output_ddr_layer_base_adr, row_shift, x_word,
                                  cur_oy_start + oy_counter,
                                  cur_of_start + of_counter + channel_counter);
    end
  end

  // previous conv word, the low half of an 8x8 pair
  always_ff @(posedge clk) begin
    conv_hist <= fifo_data.m0.conv;
  end

  always_comb begin
    conv_out_ddr_data = '0;
    if (valid_conv_out_ddr_data) begin
      if (mode == mode_8x8) begin
        conv_out_ddr_data = {fifo_data.m0.conv, conv_hist};
      end else begin
        conv_out_ddr_data = {fifo_data.m1.hi, fifo_data.m1.lo};
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/conv_store_pkg.sv ====
`default_nettype none

package conv_store_pkg;

  ////////////////////
  // conv core geometry
  ////////////////////
  localparam int sa_row_num = 4;
  localparam int sa_column_num = 3;
  localparam int fifo_num = sa_row_num * sa_column_num;

  // output channels held by one array row in 8x8 mode
  localparam int row_num_in_sa = 16;
  localparam int row_num_in_sa_in2pow = 4;

  // ddr address stepping
  localparam int pixels_in_row_in_2pow = 5;
  localparam int ofs_in_row_2pow = 1;

  // word widths
  localparam int conv_word_width = 256;
  localparam int fifo_word_width = 512;
  localparam int ddr_word_width = 512;

  typedef enum logic [3:0] {
    mode_8x8 = 4'd0,
    mode_1x8 = 4'd1
  } store_mode_e;

  // one fifo word, read as a single conv word in 8x8 mode
  // or as a pair of conv words in 1x8 mode
  typedef union packed {
    struct packed {
      logic [fifo_word_width-conv_word_width-1:0] unused;
      logic [conv_word_width-1:0] conv;
    } m0;
    struct packed {
      logic [conv_word_width-1:0] hi;
      logic [conv_word_width-1:0] lo;
    } m1;
  } fifo_word_u;

endpackage

`default_nettype wire

// ==== rtl/conv_store_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_store_top #(
  parameter int fifo_depth = 64,
  parameter int ddr_cmd_word_num = 32
) (
  input wire clk,
  input wire reset,
  input wire layer_start,
  input wire tile_done,
  input wire [15:0] layer_ox_num,
  input wire [15:0] layer_oy_num,
  input wire [15:0] layer_of_num,
  input wire [15:0] tile_pox,
  input wire [15:0] tile_poy,
  input wire [15:0] tile_pof,
  input wire [31:0] output_ddr_layer_base_adr,
  input wire conv_store_pkg::store_mode_e mode,
  input wire [3:0] of_in_2pow,
  input wire [3:0] ox_in_2pow,
  input wire [conv_store_pkg::fifo_num-1:0] fifo_wr,
  input wire conv_store_pkg::fifo_word_u fifo_wr_data,
  output logic fifo_overflow,
  input wire ddr_cmd_ready,
  input wire ddr_wt_data_ready,
  output logic [31:0] store_ddr_base_adr,
  output logic [15:0] store_ddr_length,
  output logic valid_store_ddr_cmd,
  output logic [31:0] conv_out_ddr_adr,
  output logic [conv_store_pkg::ddr_word_width-1:0] conv_out_ddr_data,
  output logic valid_conv_out_ddr_data,
  output logic layer_done
);
  import conv_store_pkg::*;

  // sequencer to controller
  logic conv_store_start;
  logic conv_store_fin;
  logic [15:0] cur_ox_start;
  logic [15:0] cur_oy_start;
  logic [15:0] cur_of_start;
  logic [15:0] cur_poy;
  logic [15:0] cur_pof;

  // controller to fifo bank
  logic [fifo_num-1:0] fifo_rds;
  fifo_word_u fifo_data;

  store_tile_sequencer i_sequencer (
    .clk(clk),
    .reset(reset),
    .layer_start(layer_start),
    .tile_done(tile_done),
    .conv_store_fin(conv_store_fin),
    .layer_ox_num(layer_ox_num),
    .layer_oy_num(layer_oy_num),
    .layer_of_num(layer_of_num),
    .tile_pox(tile_pox),
    .tile_poy(tile_poy),
    .tile_pof(tile_pof),
    .conv_store_start(conv_store_start),
    .cur_ox_start(cur_ox_start),
    .cur_oy_start(cur_oy_start),
    .cur_of_start(cur_of_start),
    .cur_poy(cur_poy),
    .cur_pof(cur_pof),
    .layer_done(layer_done)
  );

  conv_out_fifo_bank #(
    .fifo_depth(fifo_depth)
  ) i_fifo_bank (
    .clk(clk),
    .reset(reset),
    .fifo_wr(fifo_wr),
    .fifo_wr_data(fifo_wr_data),
    .fifo_rds(fifo_rds),
    .fifo_data(fifo_data),
    .fifo_overflow(fifo_overflow)
  );

  conv_store_ddr_controller #(
    .ddr_cmd_word_num(ddr_cmd_word_num)
  ) i_store_ctrl (
    .clk(clk),
    .reset(reset),
    .conv_store_start(conv_store_start),
    .ddr_cmd_ready(ddr_cmd_ready),
    .ddr_wt_data_ready(ddr_wt_data_ready),
    .output_ddr_layer_base_adr(output_ddr_layer_base_adr),
    .mode(mode),
    .of_in_2pow(of_in_2pow),
    .ox_in_2pow(ox_in_2pow),
    .cur_ox_start(cur_ox_start),
    .cur_oy_start(cur_oy_start),
    .cur_of_start(cur_of_start),
    .cur_poy(cur_poy),
    .cur_pof(cur_pof),
    .store_ddr_base_adr(store_ddr_base_adr),
    .store_ddr_length(store_ddr_length),
    .valid_store_ddr_cmd(valid_store_ddr_cmd),
    .fifo_rds(fifo_rds),
    .fifo_data(fifo_data),
    .conv_out_ddr_adr(conv_out_ddr_adr),
    .conv_out_ddr_data(conv_out_ddr_data),
    .valid_conv_out_ddr_data(valid_conv_out_ddr_data),
    .conv_store_fin(conv_store_fin)
  );

endmodule

`default_nettype wire

// ==== rtl/store_tile_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_tile_sequencer (
  input wire clk,
  input wire reset,
  input wire layer_start,
  input wire tile_done,
  input wire conv_store_fin,
  input wire [15:0] layer_ox_num,
  input wire [15:0] layer_oy_num,
  input wire [15:0] layer_of_num,
  input wire [15:0] tile_pox,
  input wire [15:0] tile_poy,
  input wire [15:0] tile_pof,
  output logic conv_store_start,
  output logic [15:0] cur_ox_start,
  output logic [15:0] cur_oy_start,
  output logic [15:0] cur_of_start,
  output logic [15:0] cur_poy,
  output logic [15:0] cur_pof,
  output logic layer_done
);

  logic layer_active;
  logic store_busy;
  logic tile_accept;
  logic last_tile;
  logic [16:0] of_next;
  logic [16:0] ox_next;
  logic [16:0] oy_next;
  logic of_wrap;
  logic ox_wrap;
  logic oy_wrap;
  logic [15:0] of_left;
  logic [15:0] oy_left;

  ////////////////////
  // next tile origin
  ////////////////////
  assign of_next = 17'(cur_of_start) + 17'(tile_pof);
  assign ox_next = 17'(cur_ox_start) + 17'(tile_pox);
  assign oy_next = 17'(cur_oy_start) + 17'(tile_poy);
  assign of_wrap = of_next >= 17'(layer_of_num);
  assign ox_wrap = ox_next >= 17'(layer_ox_num);
  assign oy_wrap = oy_next >= 17'(layer_oy_num);
  assign last_tile = of_wrap && ox_wrap && oy_wrap;

  // room left to the layer edge
  assign of_left = layer_of_num - cur_of_start;
  assign oy_left = layer_oy_num - cur_oy_start;

  assign tile_accept = tile_done && layer_active && !store_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      layer_active <= 1'b0;
      store_busy <= 1'b0;
      conv_store_start <= 1'b0;
      layer_done <= 1'b0;
    end else begin
      conv_store_start <= tile_accept;
      layer_done <= conv_store_fin && layer_active && last_tile;
      if (layer_start) begin
        layer_active <= 1'b1;
      end else if (conv_store_fin && last_tile) begin
        layer_active <= 1'b0;
      end
      if (tile_accept) begin
        store_busy <= 1'b1;
      end else if (conv_store_fin) begin
        store_busy <= 1'b0;
      end
    end
  end

  // filter steps fastest, then x, then y
  always_ff @(posedge clk) begin
    if (reset || layer_start) begin
      cur_of_start <= '0;
      cur_ox_start <= '0;
      cur_oy_start <= '0;
    end else if (conv_store_fin && layer_active) begin
      if (!of_wrap) begin
        cur_of_start <= of_next[15:0];
      end else begin
        cur_of_start <= '0;
        if (!ox_wrap) begin
          cur_ox_start <= ox_next[15:0];
        end else begin
          cur_ox_start <= '0;
          cur_oy_start <= oy_wrap ? '0 : oy_next[15:0];
        end
      end
    end
  end

  // last tile clipped to the layer edge
  always_ff @(posedge clk) begin
    if (tile_accept) begin
      cur_pof <= (of_left < tile_pof) ? of_left : tile_pof;
      cur_poy <= (oy_left < tile_poy) ? oy_left : tile_poy;
    end
  end

endmodule

`default_nettype wire

// ==== verif/conv_store_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module conv_store_tb;
  import conv_store_pkg::*;

  // fifo words written over all tests, four cycles each plus slack
  localparam int fifo_words_total = 384 + 192 + 96;
  localparam int cycle_limit = 4 * fifo_words_total + 200;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic layer_start = 1'b0;
  logic tile_done = 1'b0;
  logic [15:0] layer_ox_num = '0;
  logic [15:0] layer_oy_num = '0;
  logic [15:0] layer_of_num = '0;
  logic [15:0] tile_pox = '0;
  logic [15:0] tile_poy = '0;
  logic [15:0] tile_pof = '0;
  logic [31:0] output_ddr_layer_base_adr = 32'h0010_0000;
  store_mode_e mode = mode_8x8;
  logic [3:0] of_in_2pow = '0;
  logic [3:0] ox_in_2pow = '0;
  logic [fifo_num-1:0] fifo_wr = '0;
  fifo_word_u fifo_wr_data = '0;
  logic stall_en = 1'b0;
  wire fifo_overflow;
  wire ddr_cmd_ready;
  wire ddr_wt_data_ready;
  wire [31:0] store_ddr_base_adr;
  wire [15:0] store_ddr_length;
  wire valid_store_ddr_cmd;
  wire [31:0] conv_out_ddr_adr;
  wire [ddr_word_width-1:0] conv_out_ddr_data;
  wire valid_conv_out_ddr_data;
  wire layer_done;
  wire cmd_seen;
  wire [31:0] cmd_base;
  wire [15:0] cmd_len;
  wire word_seen;
  wire [31:0] word_adr;
  wire [511:0] word_data;

  // reference queues
  logic [31:0] exp_cmd_adr [$];
  logic [15:0] exp_cmd_len [$];
  logic [31:0] exp_adr [$];
  logic [511:0] exp_data [$];

  string cur_test = "none";
  int errors = 0;
  int tests = 0;
  int cycle_count = 0;
  int fin_count = 0;
  int done_count = 0;
  int burst_words = 0;
  int cmds_total = 0;
  int words_total = 0;
  logic [15:0] last_len = '0;
  logic cmd_open = 1'b0;
  logic layer_started = 1'b0;

  conv_store_top #(
    .fifo_depth(64),
    .ddr_cmd_word_num(32)
  ) i_dut (
    .clk(clk),
    .reset(reset),
    .layer_start(layer_start),
    .tile_done(tile_done),
    .layer_ox_num(layer_ox_num),
    .layer_oy_num(layer_oy_num),
    .layer_of_num(layer_of_num),
    .tile_pox(tile_pox),
    .tile_poy(tile_poy),
    .tile_pof(tile_pof),
    .output_ddr_layer_base_adr(output_ddr_layer_base_adr),
    .mode(mode),
    .of_in_2pow(of_in_2pow),
    .ox_in_2pow(ox_in_2pow),
    .fifo_wr(fifo_wr),
    .fifo_wr_data(fifo_wr_data),
    .fifo_overflow(fifo_overflow),
    .ddr_cmd_ready(ddr_cmd_ready),
    .ddr_wt_data_ready(ddr_wt_data_ready),
    .store_ddr_base_adr(store_ddr_base_adr),
    .store_ddr_length(store_ddr_length),
    .valid_store_ddr_cmd(valid_store_ddr_cmd),
    .conv_out_ddr_adr(conv_out_ddr_adr),
    .conv_out_ddr_data(conv_out_ddr_data),
    .valid_conv_out_ddr_data(valid_conv_out_ddr_data),
    .layer_done(layer_done)
  );

  ddr_store_model i_ddr (
    .clk(clk),
    .reset(reset),
    .stall_en(stall_en),
    .ddr_cmd_ready(ddr_cmd_ready),
    .ddr_wt_data_ready(ddr_wt_data_ready),
    .valid_store_ddr_cmd(valid_store_ddr_cmd),
    .store_ddr_base_adr(store_ddr_base_adr),
    .store_ddr_length(store_ddr_length),
    .valid_conv_out_ddr_data(valid_conv_out_ddr_data),
    .conv_out_ddr_adr(conv_out_ddr_adr),
    .conv_out_ddr_data(conv_out_ddr_data),
    .cmd_seen(cmd_seen),
    .cmd_base(cmd_base),
    .cmd_len(cmd_len),
    .word_seen(word_seen),
    .word_adr(word_adr),
    .word_data(word_data)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout after %0d cycles in test %s", cycle_count, cur_test);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////
  // protocol properties
  ////////////////////
  idle_before_layer: assert property (@(posedge clk) disable iff (reset)
    !layer_started |-> !((i_dut.fifo_rds != '0) || valid_store_ddr_cmd ||
                         valid_conv_out_ddr_data || i_dut.conv_store_start ||
                         i_dut.conv_store_fin || layer_done))
    else begin
      errors++;
      $display("%s: control output active before layer_start", cur_test);
    end

  no_overflow: assert property (@(posedge clk) disable iff (reset) !fifo_overflow)
    else begin
      errors++;
      $display("%s: fifo overflow raised", cur_test);
    end

  always @(posedge clk) begin
    if (!reset && i_dut.conv_store_fin) begin
      fin_count++;
    end
    if (!reset && layer_done) begin
      done_count++;
    end
  end

  ////////////////////
  // scoreboard
  ////////////////////
  always @(negedge clk) begin
    logic [31:0] ea;
    logic [15:0] el;
    logic [511:0] ed;
    if (word_seen) begin
      words_total++;
      burst_words++;
      assert (exp_adr.size() != 0) else begin
        errors++;
        $display("%s: data word arrived with none expected", cur_test);
      end
      if (exp_adr.size() != 0) begin
        ea = exp_adr.pop_front();
        ed = exp_data.pop_front();
        assert (word_adr == ea) else begin
          errors++;
          $display("mismatch %s data adr: expected %h actual %h", cur_test, ea, word_adr);
        end
        assert (word_data == ed) else begin
          errors++;
          $display("mismatch %s data: expected %h actual %h", cur_test, ed, word_data);
        end
      end
    end
    if (cmd_seen) begin
      cmds_total++;
      // previous burst must be complete
      assert (!cmd_open || burst_words == int'(last_len)) else begin
        errors++;
        $display("mismatch %s burst words: expected %0d actual %0d", cur_test, last_len,
                 burst_words);
      end
      assert (exp_cmd_adr.size() != 0) else begin
        errors++;
        $display("%s: command issued with none expected", cur_test);
      end
      if (exp_cmd_adr.size() != 0) begin
        ea = exp_cmd_adr.pop_front();
        el = exp_cmd_len.pop_front();
        assert (cmd_base == ea) else begin
          errors++;
          $display("mismatch %s cmd adr: expected %h actual %h", cur_test, ea, cmd_base);
        end
        assert (cmd_len == el) else begin
          errors++;
          $display("mismatch %s cmd len: expected %0d actual %0d", cur_test, el, cmd_len);
        end
        last_len = el;
      end
      burst_words = 0;
      cmd_open = 1'b1;
    end
  end

  ////////////////////
  // reference model
  ////////////////////
  function automatic logic [31:0] ddr_address(input int row, input int ch, input int ox,
                                              input int of2, input int ox2);
    logic [31:0] row_term;
    logic [31:0] x_term;
    row_term = 32'(row) << (of2 - 1 + ox2 - 5);
    x_term = (32'(ox) << (of2 - 1)) >> 5;
    return output_ddr_layer_base_adr + row_term + x_term + (32'(ch) >> 1);
  endfunction

  // tag of tile, row and channel, repeated across the conv word
  function automatic logic [255:0] conv_word(input int tile, input int r, input int c);
    logic [31:0] tag;
    tag = {8'(tile), 8'(r), 16'(c)};
    return {8{tag}};
  endfunction

  task automatic write_fifo(input int idx, input logic [511:0] d);
    @(posedge clk);
    #1;
    fifo_wr = fifo_num'(1) << idx;
    fifo_wr_data = d;
  endtask

  task automatic load_tile(input int tile, input int of, input int ox, input int oy,
                           input int pof, input int poy);
    logic [255:0] lo;
    logic [255:0] hi;
    int soc;
    int len;
    for (int r = 0; r < poy; r++) begin
      for (int c = 0; c < pof; c += 2) begin
        lo = conv_word(tile, r, c);
        hi = conv_word(tile, r, c + 1);
        if (mode == mode_8x8) begin
          // upper half of an 8x8 fifo word carries junk
          write_fifo(r * 4 + c / 16, {~lo, lo});
          write_fifo(r * 4 + c / 16, {~hi, hi});
        end else begin
          write_fifo(r * 4 + c / 32, {hi, lo});
        end
        exp_data.push_back({hi, lo});
        exp_adr.push_back(ddr_address(oy + r, of + c, ox, of_in_2pow, ox_in_2pow));
      end
      soc = 0;
      while (soc < pof) begin
        len = ((pof - soc) / 2 < 32) ? (pof - soc) / 2 : 32;
        exp_cmd_adr.push_back(ddr_address(oy + r, of + soc, ox, of_in_2pow, ox_in_2pow));
        exp_cmd_len.push_back(16'(len));
        soc += 2 * len;
      end
    end
    @(posedge clk);
    #1;
    fifo_wr = '0;
  endtask

  task automatic run_layer(input string name, input store_mode_e m, input int of_num,
                           input int ox_num, input int oy_num, input int tpof,
                           input int tpox, input int tpoy, input int of2, input int ox2,
                           input logic stall);
    int pof;
    int poy;
    int tiles;
    int err0;
    int fin0;
    int done0;
    cur_test = name;
    err0 = errors;
    fin0 = fin_count;
    done0 = done_count;
    tiles = 0;
    @(posedge clk);
    #1;
    mode = m;
    layer_of_num = 16'(of_num);
    layer_ox_num = 16'(ox_num);
    layer_oy_num = 16'(oy_num);
    tile_pof = 16'(tpof);
    tile_pox = 16'(tpox);
    tile_poy = 16'(tpoy);
    of_in_2pow = 4'(of2);
    ox_in_2pow = 4'(ox2);
    stall_en = stall;
    layer_started = 1'b1;
    layer_start = 1'b1;
    @(posedge clk);
    #1;
    layer_start = 1'b0;
    // filter fastest, then x, then y
    for (int oy = 0; oy < oy_num; oy += tpoy) begin
      for (int ox = 0; ox < ox_num; ox += tpox) begin
        for (int of = 0; of < of_num; of += tpof) begin
          pof = (of_num - of < tpof) ? of_num - of : tpof;
          poy = (oy_num - oy < tpoy) ? oy_num - oy : tpoy;
          load_tile(tiles, of, ox, oy, pof, poy);
          tile_done = 1'b1;
          @(posedge clk);
          #1;
          tile_done = 1'b0;
          tiles++;
          while (fin_count < fin0 + tiles) begin
            @(negedge clk);
          end
        end
      end
    end
    while (done_count < done0 + 1) begin
      @(negedge clk);
    end
    repeat (4) @(posedge clk);
    #2;
    assert (exp_adr.size() == 0 && exp_cmd_adr.size() == 0) else begin
      errors++;
      $display("%s: %0d data words and %0d commands never arrived", name, exp_adr.size(),
               exp_cmd_adr.size());
    end
    assert (fin_count - fin0 == tiles) else begin
      errors++;
      $display("mismatch %s fin pulses: expected %0d actual %0d", name, tiles,
               fin_count - fin0);
    end
    assert (done_count - done0 == 1) else begin
      errors++;
      $display("mismatch %s layer_done pulses: expected 1 actual %0d", name,
               done_count - done0);
    end
    assert (!cmd_open || burst_words == int'(last_len)) else begin
      errors++;
      $display("mismatch %s last burst: expected %0d actual %0d", name, last_len, burst_words);
    end
    cmd_open = 1'b0;
    burst_words = 0;
    tests++;
    $display("test %s: %0d tiles, %0d errors", name, tiles, errors - err0);
  endtask

  initial begin
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // outputs stay quiet with ready high and no layer
    cur_test = "reset_idle";
    repeat (20) @(posedge clk);
    #2;
    assert (cmds_total == 0 && words_total == 0) else begin
      errors++;
      $display("reset_idle: traffic seen before layer_start");
    end
    tests++;
    $display("test reset_idle: %0d errors", errors);

    run_layer("mode0_pack", mode_8x8, 48, 64, 4, 32, 32, 3, 6, 6, 1'b0);
    run_layer("mode1_multi_cmd", mode_1x8, 96, 64, 2, 96, 32, 2, 7, 5, 1'b0);
    run_layer("random_stall", mode_8x8, 32, 32, 3, 32, 32, 2, 5, 5, 1'b1);

    $display("%0d tests, %0d commands, %0d data words, %0d errors", tests, cmds_total,
             words_total, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/ddr_store_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module ddr_store_model (
  input wire clk,
  input wire reset,
  input wire stall_en,
  output logic ddr_cmd_ready,
  output logic ddr_wt_data_ready,
  input wire valid_store_ddr_cmd,
  input wire [31:0] store_ddr_base_adr,
  input wire [15:0] store_ddr_length,
  input wire valid_conv_out_ddr_data,
  input wire [31:0] conv_out_ddr_adr,
  input wire [511:0] conv_out_ddr_data,
  output logic cmd_seen,
  output logic [31:0] cmd_base,
  output logic [15:0] cmd_len,
  output logic word_seen,
  output logic [31:0] word_adr,
  output logic [511:0] word_data
);

  logic [31:0] lfsr_state;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  initial begin
    lfsr_state = 32'h8644_26be;
    ddr_cmd_ready = 1'b1;
    ddr_wt_data_ready = 1'b1;
  end

  ////////////////////
  // ready generation
  ////////////////////
  // each ready low about one cycle in four
  always begin
    logic [3:0] bits;
    @(posedge clk);
    #1;
    for (int i = 0; i < 4; i++) begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
    ddr_cmd_ready = stall_en ? (bits[0] | bits[1]) : 1'b1;
    ddr_wt_data_ready = stall_en ? (bits[2] | bits[3]) : 1'b1;
  end

  ////////////////////
  // capture
  ////////////////////
  always @(posedge clk) begin
    cmd_seen <= !reset && valid_store_ddr_cmd;
    cmd_base <= store_ddr_base_adr;
    cmd_len <= store_ddr_length;
    word_seen <= !reset && valid_conv_out_ddr_data;
    word_adr <= conv_out_ddr_adr;
    word_data <= conv_out_ddr_data;
  end

endmodule

`default_nettype wire
